// ==== bench/datapath_core_sva.sv ====
module datapath_core_sva
    import dsp_const_pkg::*;
#(
    parameter int err_latency = 2
) (
    input logic       clk,
    input logic       rst_n_i,
    input bit_word_t  bits_o,
    input code_word_t error_o
);

    a_zero_in_reset: assert property (@(posedge clk)
        (!rst_n_i && !$past(rst_n_i)) |-> (bits_o == '0 && error_o == '0))
        else $error("bits_o or error_o not zero while reset is held");

    // Bit delay line still carries reset values
    a_bits_after_release: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (bits_o == '0) [*(err_latency + 1)])
        else $error("bits_o left zero too early after reset release");

    a_error_after_release: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (error_o == '0) [*2])
        else $error("error_o left zero too early after reset release");

    a_known_outputs: assert property (@(posedge clk)
        rst_n_i |-> !$isunknown({bits_o, error_o}))
        else $error("bits_o or error_o unknown out of reset");

endmodule : datapath_core_sva

bind datapath_core datapath_core_sva #(
    .err_latency(channel_pipeline_depth + 1)
) sva_i (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .bits_o  (bits_o),
    .error_o (error_o)
);

// ==== include/dsp_ref_model.svh ====
`ifndef DSP_REF_MODEL_SVH
`define DSP_REF_MODEL_SVH

// Expected decisions for cur, with prev the word sent just before it
function automatic bit_word_t model_bits(input code_word_t cur,
                                         input code_word_t prev,
                                         input dsp_cfg_t   cfg);
    bit_word_t bits;
    code_t [2*channel_width-1:0] window;
    int acc;
    int eq;

    window = {cur, prev};
    for (int i = 0; i < channel_width; i++) begin
        acc = 0;
        for (int k = 0; k < ffe_length; k++) begin
            acc += int'($signed(window[channel_width+i-k]))
                 * int'($signed(cfg.weights[i][k]));
        end
        eq = acc >>> cfg.ffe_shift[i];
        bits[i] = (eq >= int'($signed(cfg.thresh[i])));
    end
    return bits;
endfunction : model_bits

// Expected residual of code against the estimate rebuilt from two bit words
function automatic code_word_t model_error(input bit_word_t  cur_bits,
                                           input bit_word_t  prev_bits,
                                           input code_word_t code,
                                           input dsp_cfg_t   cfg);
    code_word_t err;
    logic [2*channel_width-1:0] window;
    int tap;
    int acc;
    int rebuilt;
    int diff;

    window = {cur_bits, prev_bits};
    for (int i = 0; i < channel_width; i++) begin
        acc = 0;
        for (int k = 0; k < est_channel_depth; k++) begin
            tap = int'($signed(cfg.channel_est[i][k]));
            acc += window[channel_width+i-k] ? tap : -tap;
        end
        rebuilt = acc >>> cfg.channel_shift[i];
        diff = int'($signed(code[i])) - rebuilt;
        if (diff > 2**(code_precision-1) - 1) begin
            diff = 2**(code_precision-1) - 1;
        end else if (diff < -(2**(code_precision-1))) begin
            diff = -(2**(code_precision-1));
        end
        err[i] = code_t'(diff);
    end
    return err;
endfunction : model_error

`endif

// ==== bench/test.sv ====
module test
    import dsp_const_pkg::*;
    import dsp_cfg_pkg::*;
();

    `include "dsp_ref_model.svh"

    localparam int clk_period    = 100;
    localparam int reset_cycles  = 8;
    localparam int num_runs      = 3;
    localparam int words_per_run = 400;
    localparam int ffe_depth     = 1;
    localparam int chan_depth    = 1;
    localparam int latency       = (2 + ffe_depth) + (chan_depth + 1);   // F + R
    localparam longint timeout   =
        longint'(num_runs) * (words_per_run + reset_cycles + 10) * clk_period
        + 50 * clk_period;

    typedef struct packed {
        bit_word_t  bits;
        code_word_t err;
    } expect_t;

    logic       clk;
    logic       rst_n_i;
    code_word_t codes_i;
    dsp_cfg_t   cfg_i;
    bit_word_t  bits_o;
    code_word_t error_o;

    logic [31:0] lfsr_state;
    expect_t     exp_q [$];
    code_word_t  prev_word;
    bit_word_t   prev_bits;
    int          errors;
    int          checks;

    datapath_core #(
        .channel_width          (channel_width),
        .ffe_pipeline_depth     (ffe_depth),
        .channel_pipeline_depth (chan_depth)
    ) UUT (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .codes_i (codes_i),
        .cfg_i   (cfg_i),
        .bits_o  (bits_o),
        .error_o (error_o)
    );

    always #(clk_period/2) clk = ~clk;

    // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction : lfsr_next

    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction : random_bits

    // One tap set broadcast to all lanes
    function automatic dsp_cfg_t draw_config(input bit uniform);
        dsp_cfg_t   cfg;
        weight_t    ffe_taps [ffe_length];
        est_tap_t   est_taps [est_channel_depth];
        shift_t     fs;
        shift_t     cs;
        thresh_t    th;
        logic [7:0] raw;

        for (int k = 0; k < ffe_length; k++) begin
            ffe_taps[k] = weight_t'(random_bits(weight_precision));
        end
        for (int k = 0; k < est_channel_depth; k++) begin
            est_taps[k] = est_tap_t'(random_bits(est_channel_precision));
        end
        fs = shift_t'(8 + random_bits(2));
        cs = shift_t'(random_bits(2));
        raw = 8'(random_bits(8));
        th = thresh_t'($signed(raw));
        for (int i = 0; i < channel_width; i++) begin
            for (int k = 0; k < ffe_length; k++) begin
                cfg.weights[i][k] = ffe_taps[k];
            end
            for (int k = 0; k < est_channel_depth; k++) begin
                cfg.channel_est[i][k] = est_taps[k];
            end
            if (!uniform) begin   // Lane specific shift and threshold
                fs = shift_t'(8 + random_bits(2));
                cs = shift_t'(random_bits(2));
                raw = 8'(random_bits(8));
                th = thresh_t'($signed(raw));
            end
            cfg.ffe_shift[i]     = fs;
            cfg.channel_shift[i] = cs;
            cfg.thresh[i]        = th;
        end
        return cfg;
    endfunction : draw_config

    function automatic code_word_t make_word(input int n);
        code_word_t w;
        code_t      same;
        same = code_t'(random_bits(code_precision));
        for (int i = 0; i < channel_width; i++) begin
            w[i] = code_t'(random_bits(code_precision));
        end
        if (n % 8 == 3) begin
            for (int i = 0; i < channel_width; i++) begin
                w[i] = same;
            end
        end else if (n % 8 == 7) begin
            // Extreme high lanes feed lane 0 of the next word
            for (int i = channel_width / 2; i < channel_width; i++) begin
                if (random_bits(1) != 0) begin
                    w[i] = {1'b0, {(code_precision-1){1'b1}}};
                end else begin
                    w[i] = {1'b1, {(code_precision-1){1'b0}}};
                end
            end
        end
        return w;
    endfunction : make_word

    task automatic check_output();
        expect_t e;
        e = exp_q.pop_front();
        checks += 2;
        assert (bits_o === e.bits) else begin
            errors++;
            $display("ERROR: bits_o = %h, expected %h at %0t", bits_o, e.bits, $time);
        end
        assert (error_o === e.err) else begin
            errors++;
            $display("ERROR: error_o = %h, expected %h at %0t", error_o, e.err, $time);
        end
    endtask : check_output

    task automatic apply_reset(input dsp_cfg_t cfg);
        @(negedge clk);
        rst_n_i = 1'b0;
        codes_i = '0;
        cfg_i   = cfg;
        repeat (reset_cycles) begin
            @(negedge clk);
            checks++;
            assert (bits_o === '0 && error_o === '0) else begin
                errors++;
                $display("ERROR: bits_o = %h, error_o = %h in reset, expected 0",
                         bits_o, error_o);
            end
        end
        rst_n_i = 1'b1;
        exp_q.delete();
        prev_word = '0;   // History is cleared
        prev_bits = model_bits('0, '0, cfg_i);
    endtask : apply_reset

    task automatic run_words();
        code_word_t w;
        expect_t    e;
        for (int n = 0; n < words_per_run; n++) begin
            @(negedge clk);
            if (exp_q.size() == latency) begin
                check_output();
            end
            w = make_word(n);
            codes_i = w;
            e.bits = model_bits(w, prev_word, cfg_i);
            e.err  = model_error(e.bits, prev_bits, w, cfg_i);
            exp_q.push_back(e);
            prev_word = w;
            prev_bits = e.bits;
        end
        // Fresh words fill the history that the next reset must clear
        while (exp_q.size() > 0) begin
            @(negedge clk);
            check_output();
            codes_i = make_word(words_per_run);
        end
    endtask : run_words

    initial begin
        clk        = 1'b0;
        rst_n_i    = 1'b0;
        codes_i    = '0;
        cfg_i      = '0;
        lfsr_state = 32'd82457;
        errors     = 0;
        checks     = 0;
        for (int run = 0; run < num_runs; run++) begin
            apply_reset(draw_config(run == num_runs - 1));   // Last run is uniform
            run_words();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(timeout);
        $display("TIMEOUT: the test did not complete within %0d time units", timeout);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule : test

// ==== design/datapath_core.sv ====
module datapath_core
    import dsp_const_pkg::*;
    import dsp_cfg_pkg::*;
#(
    parameter int channel_width          = dsp_const_pkg::channel_width,
    parameter int ffe_pipeline_depth     = 1,
    parameter int channel_pipeline_depth = 1
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  code_word_t codes_i,
    input  dsp_cfg_t   cfg_i,
    output bit_word_t  bits_o,
    output code_word_t error_o
);

    // Register stages in the FFE and in the residual stage
    localparam int ffe_latency = 2 + ffe_pipeline_depth;
    localparam int err_latency = channel_pipeline_depth + 1;

    bit_word_t  ffe_bits;
    code_word_t codes_aligned;

    // Lane count is fixed by the word types
    if (channel_width != $bits(bit_word_t)) begin : g_width_check
        $error("channel_width does not match the package word types");
    end

    if (ffe_length > channel_width || est_channel_depth > channel_width) begin : g_tap_check
        $error("tap count exceeds the lane count");
    end

    ffe_filter #(
        .ffe_pipeline_depth(ffe_pipeline_depth)
    ) ffe_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .codes_i (codes_i),
        .cfg_i   (cfg_i),
        .bits_o  (ffe_bits)
    );

    // Codes meet the rebuilt value at the error register
    pipeline_delay #(
        .depth     (ffe_latency + err_latency - 1),
        .payload_t (code_word_t)
    ) code_align (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .data_i  (codes_i),
        .data_o  (codes_aligned)
    );

    residual_error #(
        .channel_pipeline_depth(channel_pipeline_depth)
    ) err_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bits_i  (ffe_bits),
        .codes_i (codes_aligned),
        .cfg_i   (cfg_i),
        .error_o (error_o)
    );

    pipeline_delay #(
        .depth     (err_latency),
        .payload_t (bit_word_t)
    ) bit_align (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .data_i  (ffe_bits),
        .data_o  (bits_o)
    );

endmodule : datapath_core

// ==== design/dsp_cfg_pkg.sv ====
package dsp_cfg_pkg;

    import dsp_const_pkg::*;

    typedef logic signed [weight_precision-1:0] weight_t;

    typedef logic signed [est_channel_precision-1:0] est_tap_t;

    typedef logic [3:0] shift_t;   // Right shift amount

    typedef logic signed [eq_width-1:0] thresh_t;

    // Tap k of lane i multiplies code i-k
    typedef weight_t [channel_width-1:0][ffe_length-1:0] ffe_weights_t;

    typedef est_tap_t [channel_width-1:0][est_channel_depth-1:0] channel_est_t;

    typedef shift_t [channel_width-1:0] shift_word_t;

    typedef thresh_t [channel_width-1:0] thresh_word_t;

    // Static settings held after reset
    typedef struct packed {
        ffe_weights_t weights;
        channel_est_t channel_est;
        shift_word_t  ffe_shift;
        shift_word_t  channel_shift;
        thresh_word_t thresh;
    } dsp_cfg_t;

endpackage : dsp_cfg_pkg

// ==== design/dsp_const_pkg.sv ====
package dsp_const_pkg;

    localparam int channel_width         = 8;
    localparam int code_precision        = 8;
    localparam int weight_precision      = 10;
    localparam int ffe_length            = 4;   // Must not exceed channel_width
    localparam int est_channel_precision = 8;
    localparam int est_channel_depth     = 4;   // Must not exceed channel_width

    // Full precision FFE sum
    localparam int eq_width = code_precision + weight_precision + $clog2(ffe_length);

    // Extra bit covers negated most negative taps
    localparam int est_sum_width = est_channel_precision + $clog2(est_channel_depth) + 1;

    typedef logic signed [code_precision-1:0] code_t;

    typedef code_t [channel_width-1:0] code_word_t;

    typedef logic [channel_width-1:0] bit_word_t;   // One decision per lane

endpackage : dsp_const_pkg

// ==== design/ffe_filter.sv ====
module ffe_filter
    import dsp_const_pkg::*;
    import dsp_cfg_pkg::*;
#(
    parameter int ffe_pipeline_depth = 1
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  code_word_t codes_i,
    input  dsp_cfg_t   cfg_i,
    output bit_word_t  bits_o
);

    typedef logic signed [eq_width-1:0] eq_t;
    typedef eq_t [channel_width-1:0] eq_word_t;

    code_word_t cur_q;
    code_word_t prev_q;
    code_t [2*channel_width-1:0] window;

    eq_word_t eq_comb;
    eq_word_t eq_out;
    bit_word_t slice_q;

    // Current and previous word
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cur_q  <= '0;
            prev_q <= '0;
        end else begin
            cur_q  <= codes_i;
            prev_q <= cur_q;
        end
    end

    // Low lanes of the window are the previous word
    assign window = {cur_q, prev_q};

    always_comb begin
        eq_t acc;
        for (int i = 0; i < channel_width; i++) begin
            acc = '0;
            for (int k = 0; k < ffe_length; k++) begin
                acc = acc + $signed(window[channel_width+i-k])
                          * $signed(cfg_i.weights[i][k]);
            end
            eq_comb[i] = acc >>> cfg_i.ffe_shift[i];
        end
    end

    if (ffe_pipeline_depth == 0) begin : g_no_pipe
        assign eq_out = eq_comb;
    end else begin : g_pipe
        eq_word_t eq_q [ffe_pipeline_depth];

        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                for (int s = 0; s < ffe_pipeline_depth; s++) begin
                    eq_q[s] <= '0;
                end
            end else begin
                eq_q[0] <= eq_comb;
                for (int s = 1; s < ffe_pipeline_depth; s++) begin
                    eq_q[s] <= eq_q[s-1];
                end
            end
        end

        assign eq_out = eq_q[ffe_pipeline_depth-1];
    end

    // Slice to one at or above threshold
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slice_q <= '0;
        end else begin
            for (int i = 0; i < channel_width; i++) begin
                slice_q[i] <= ($signed(eq_out[i]) >= $signed(cfg_i.thresh[i]));
            end
        end
    end

    assign bits_o = slice_q;

endmodule : ffe_filter

// ==== design/pipeline_delay.sv ====
module pipeline_delay #(
    parameter int  depth     = 1,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  payload_t data_i,
    output payload_t data_o
);

    payload_t stage_q [depth];

    if (depth < 1) begin : g_depth_check
        $error("pipeline_delay needs a depth of at least one");
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < depth; k++) begin
                stage_q[k] <= '0;
            end
        end else begin
            stage_q[0] <= data_i;
            for (int k = 1; k < depth; k++) begin
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    assign data_o = stage_q[depth-1];

endmodule : pipeline_delay

// ==== design/residual_error.sv ====
module residual_error
    import dsp_const_pkg::*;
    import dsp_cfg_pkg::*;
#(
    parameter int channel_pipeline_depth = 1
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  bit_word_t  bits_i,
    input  code_word_t codes_i,     // Aligned with the rebuilt value
    input  dsp_cfg_t   cfg_i,
    output code_word_t error_o
);

    localparam int diff_width =
        ((est_sum_width > code_precision) ? est_sum_width : code_precision) + 1;
    localparam int code_max = 2**(code_precision-1) - 1;
    localparam int code_min = -(2**(code_precision-1));

    typedef logic signed [est_sum_width-1:0] est_sum_t;
    typedef est_sum_t [channel_width-1:0] est_word_t;
    typedef logic signed [diff_width-1:0] diff_t;

    bit_word_t bits_q;
    logic [2*channel_width-1:0] bit_window;

    est_word_t rebuilt_comb;
    est_word_t rebuilt;
    code_word_t err_next;
    code_word_t err_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bits_q <= '0;
        end else begin
            bits_q <= bits_i;
        end
    end

    assign bit_window = {bits_i, bits_q};

    // Bit one counts as +1, bit zero as -1
    always_comb begin
        est_sum_t acc;
        for (int i = 0; i < channel_width; i++) begin
            acc = '0;
            for (int k = 0; k < est_channel_depth; k++) begin
                if (bit_window[channel_width+i-k]) begin
                    acc = acc + $signed(cfg_i.channel_est[i][k]);
                end else begin
                    acc = acc - $signed(cfg_i.channel_est[i][k]);
                end
            end
            rebuilt_comb[i] = acc >>> cfg_i.channel_shift[i];
        end
    end

    if (channel_pipeline_depth == 0) begin : g_no_pipe
        assign rebuilt = rebuilt_comb;
    end else begin : g_pipe
        est_word_t rebuilt_q [channel_pipeline_depth];

        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                for (int s = 0; s < channel_pipeline_depth; s++) begin
                    rebuilt_q[s] <= '0;
                end
            end else begin
                rebuilt_q[0] <= rebuilt_comb;
                for (int s = 1; s < channel_pipeline_depth; s++) begin
                    rebuilt_q[s] <= rebuilt_q[s-1];
                end
            end
        end

        assign rebuilt = rebuilt_q[channel_pipeline_depth-1];
    end

    // Residual clamped to the code range
    always_comb begin
        diff_t diff;
        for (int i = 0; i < channel_width; i++) begin
            diff = diff_t'($signed(codes_i[i])) - diff_t'($signed(rebuilt[i]));
            if (diff > code_max) begin
                err_next[i] = code_t'(code_max);
            end else if (diff < code_min) begin
                err_next[i] = code_t'(code_min);
            end else begin
                err_next[i] = code_t'(diff);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_q <= '0;
        end else begin
            err_q <= err_next;
        end
    end

    assign error_o = err_q;

endmodule : residual_error

// ==== sources.f ====
+incdir+include
design/dsp_const_pkg.sv
design/dsp_cfg_pkg.sv
design/pipeline_delay.sv
design/ffe_filter.sv
design/residual_error.sv
design/datapath_core.sv
bench/datapath_core_sva.sv
bench/test.sv
